/* flist.f */
+incdir+hw
hw/mbtrain_pkg.sv
hw/train_step_if.sv
hw/mbtrain_sequencer.sv
hw/substep_driver.sv
hw/lane_speed_tracker.sv
hw/mbtrain_top.sv
test/mbtrain_assert.sv
test/mbtrain_checker.sv
test/mbtrain_tb.sv

/* hw/lane_speed_tracker.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module lane_speed_tracker (
	input  logic                        clk,
	input  logic                        rst_n,
	train_step_if.user                  step,
	input  logic [`MBT_SPEED_W-1:0]     i_highest_common_speed,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_linkspeed,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_repair,
	output logic [`MBT_SPEED_W-1:0]     o_current_speed,
	output logic [`MBT_LANE_HALVES-1:0] o_tx_lanes,
	output logic [`MBT_LANE_HALVES-1:0] o_rx_lanes,
	output logic                        o_coming_from_repair
);

	logic mbinit_entry;
	logic mbinit_repair;
	logic train_repair;

	assign mbinit_entry = step.done && (step.step == mbtrain_pkg::step_none)
		&& (step.next_step == mbtrain_pkg::step_val_vref);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_current_speed <= '0;
		end else if (step.done && step.step == mbtrain_pkg::step_data_vref) begin
			o_current_speed <= i_highest_common_speed;
		end else if (step.done && step.next_step == mbtrain_pkg::step_speed_idle
			&& step.cause == mbtrain_pkg::cause_speed_degrade) begin
			o_current_speed <= o_current_speed - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tx_lanes <= '0;
			o_rx_lanes <= '0;
		end else if (mbinit_entry) begin
			o_tx_lanes <= i_tx_lanes_mbinit;
			o_rx_lanes <= i_rx_lanes_mbinit;
		end else if (step.done && step.step == mbtrain_pkg::step_link_speed
			&& |i_tx_lanes_linkspeed) begin
			// tx width is fixed here, repair only tells the partner
			o_tx_lanes <= i_tx_lanes_linkspeed & i_tx_lanes_mbinit;
		end else if (step.done && step.step == mbtrain_pkg::step_repair) begin
			o_rx_lanes <= i_rx_lanes_repair;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mbinit_repair <= 1'b0;
			train_repair  <= 1'b0;
		end else begin
			// a dead tx half at mbinit counts as a repair already done
			if (mbinit_entry && !(&i_tx_lanes_mbinit))
				mbinit_repair <= 1'b1;
			else if (step.finished)
				mbinit_repair <= 1'b0;

			if (step.done && step.next_step == mbtrain_pkg::step_repair)
				train_repair <= 1'b1;
			else if (step.step == mbtrain_pkg::step_none && !step.finished)
				train_repair <= 1'b0;
		end
	end

	assign o_coming_from_repair = mbinit_repair || train_repair;

endmodule

/* hw/mbtrain_defs.svh */
`ifndef MBTRAIN_DEFS_SVH
`define MBTRAIN_DEFS_SVH

// number of training steps, also the width of the enable and acknowledge vectors
`define MBT_STEP_COUNT 13

// sideband substate code width, equal to the step code width
`define MBT_SUBSTATE_W 4

// pattern mux select width
`define MBT_MUX_W 3

// operating speed code
`define MBT_SPEED_W 3

// eight-lane halves, bit 0 is the first half
`define MBT_LANE_HALVES 2

`endif

/* hw/mbtrain_pkg.sv */
`include "mbtrain_defs.svh"

package mbtrain_pkg;

	// step value equals its sideband substate code
	typedef enum logic [3:0] {
		step_val_vref           = 4'd0,
		step_data_vref          = 4'd1,
		step_speed_idle         = 4'd2,
		step_tx_self_cal        = 4'd3,
		step_rx_clk_cal         = 4'd4,
		step_val_train_center   = 4'd5,
		step_val_train_vref     = 4'd6,
		step_data_train_center1 = 4'd7,
		step_data_train_vref    = 4'd8,
		step_rx_deskew          = 4'd9,
		step_data_train_center2 = 4'd10,
		step_link_speed         = 4'd11,
		step_repair             = 4'd12,
		step_none               = 4'd15
	} step_t;

	typedef enum logic [1:0] {
		cause_normal,
		cause_l1_resume,
		cause_speed_degrade
	} cause_t;

	// result of the link speed step
	typedef enum logic [1:0] {
		outcome_finish,
		outcome_retrain,
		outcome_degrade,
		outcome_repair
	} outcome_t;

	function automatic logic [`MBT_MUX_W-1:0] step_mux_sel(input step_t s);
		case (s)
			step_speed_idle, step_tx_self_cal: return 3'd1;
			step_link_speed: return 3'd2;
			step_repair: return 3'd3;
			step_val_train_center, step_data_train_center1,
			step_data_train_center2: return 3'd4;
			step_rx_clk_cal, step_rx_deskew: return 3'd5;
			// vref steps and idle
			default: return 3'd0;
		endcase
	endfunction

endpackage

/* hw/mbtrain_sequencer.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module mbtrain_sequencer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_en,
	input  logic [1:0]                 i_resolved_state,
	input  logic                       i_coming_from_l1,
	input  logic [`MBT_STEP_COUNT-1:0] i_step_ack,
	input  logic                       i_retrain_req,
	input  logic                       i_error_req,
	input  logic                       i_degrade_req,
	output logic                       o_mbtrain_ack,
	output logic                       o_phyretrain_en,
	train_step_if.seq                  step
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_run,
		ph_drain,
		ph_finish
	} phase_t;

	phase_t                  phase;
	mbtrain_pkg::step_t      cur_step;
	mbtrain_pkg::outcome_t   outcome_q;
	mbtrain_pkg::outcome_t   ls_outcome;
	mbtrain_pkg::step_t      entry_step;
	mbtrain_pkg::cause_t     entry_cause;
	mbtrain_pkg::step_t      nxt_step;
	mbtrain_pkg::cause_t     nxt_cause;
	logic [15:0]             ack_ext;
	logic                    cur_ack;
	logic                    leave_idle;
	logic                    leave_step;

	// step_none indexes past the vector and reads zero
	assign ack_ext = 16'(i_step_ack);
	assign cur_ack = ack_ext[cur_step];

	// entry point from idle
	always_comb begin
		entry_step  = mbtrain_pkg::step_speed_idle;
		entry_cause = mbtrain_pkg::cause_normal;
		if (i_coming_from_l1) begin
			entry_cause = mbtrain_pkg::cause_l1_resume;
		end else begin
			case (i_resolved_state)
				2'd0: entry_step = mbtrain_pkg::step_val_vref;
				2'd1: entry_step = mbtrain_pkg::step_tx_self_cal;
				2'd2: entry_step = mbtrain_pkg::step_repair;
				default: entry_cause = mbtrain_pkg::cause_speed_degrade;
			endcase
		end
	end

	// link speed request flags, retrain wins over error
	always_comb begin
		if (i_retrain_req)
			ls_outcome = mbtrain_pkg::outcome_retrain;
		else if (i_error_req && i_degrade_req)
			ls_outcome = mbtrain_pkg::outcome_degrade;
		else if (i_error_req)
			ls_outcome = mbtrain_pkg::outcome_repair;
		else
			ls_outcome = mbtrain_pkg::outcome_finish;
	end

	// follower of the current step, codes 0 to 11 run in order
	always_comb begin
		nxt_step  = mbtrain_pkg::step_t'(cur_step + 4'd1);
		nxt_cause = mbtrain_pkg::cause_normal;
		if (cur_step == mbtrain_pkg::step_repair) begin
			nxt_step = mbtrain_pkg::step_tx_self_cal;
		end else if (cur_step == mbtrain_pkg::step_link_speed) begin
			case (outcome_q)
				mbtrain_pkg::outcome_degrade: begin
					nxt_step  = mbtrain_pkg::step_speed_idle;
					nxt_cause = mbtrain_pkg::cause_speed_degrade;
				end
				mbtrain_pkg::outcome_repair: nxt_step = mbtrain_pkg::step_repair;
				// finish and retrain both end training
				default: nxt_step = mbtrain_pkg::step_none;
			endcase
		end
	end

	assign leave_idle = i_en && (phase == ph_idle);
	assign leave_step = i_en && (phase == ph_drain) && !cur_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= ph_idle;
			cur_step  <= mbtrain_pkg::step_none;
			outcome_q <= mbtrain_pkg::outcome_finish;
		end else if (!i_en) begin
			phase    <= ph_idle;
			cur_step <= mbtrain_pkg::step_none;
		end else begin
			case (phase)
				ph_idle: begin
					phase    <= ph_run;
					cur_step <= entry_step;
				end
				ph_run: begin
					if (cur_ack) begin
						phase <= ph_drain;
						if (cur_step == mbtrain_pkg::step_link_speed)
							outcome_q <= ls_outcome;
					end
				end
				ph_drain: begin
					// wait for the acknowledge to drop before the next enable
					if (!cur_ack) begin
						cur_step <= nxt_step;
						if (nxt_step == mbtrain_pkg::step_none)
							phase <= ph_finish;
						else
							phase <= ph_run;
					end
				end
				default: begin
					// finished, held until i_en falls
					phase <= ph_finish;
				end
			endcase
		end
	end

	assign o_mbtrain_ack   = (phase == ph_finish);
	assign o_phyretrain_en = (phase == ph_finish) && (outcome_q == mbtrain_pkg::outcome_retrain);

	assign step.step      = cur_step;
	assign step.active    = (phase == ph_run);
	assign step.done      = leave_idle || leave_step;
	assign step.next_step = leave_idle ? entry_step : nxt_step;
	assign step.cause     = leave_idle ? entry_cause : nxt_cause;
	assign step.finished  = (phase == ph_finish);

endmodule

/* hw/mbtrain_top.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module mbtrain_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_en,
	input  logic [1:0]                  i_resolved_state,
	input  logic                        i_coming_from_l1,
	input  logic [`MBT_STEP_COUNT-1:0]  i_step_ack,
	input  logic                        i_retrain_req,
	input  logic                        i_error_req,
	input  logic                        i_degrade_req,
	input  logic [`MBT_SPEED_W-1:0]     i_highest_common_speed,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_linkspeed,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_repair,
	output logic [`MBT_STEP_COUNT-1:0]  o_step_en,
	output logic [`MBT_SUBSTATE_W-1:0]  o_sideband_substate,
	output logic [`MBT_MUX_W-1:0]       o_mux_sel,
	output logic                        o_mbtrain_ack,
	output logic                        o_phyretrain_en,
	output logic [`MBT_SPEED_W-1:0]     o_current_speed,
	output logic [`MBT_LANE_HALVES-1:0] o_tx_lanes,
	output logic [`MBT_LANE_HALVES-1:0] o_rx_lanes,
	output logic                        o_coming_from_repair
);

	train_step_if step_bus ();

	mbtrain_sequencer seq_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.i_en             (i_en),
		.i_resolved_state (i_resolved_state),
		.i_coming_from_l1 (i_coming_from_l1),
		.i_step_ack       (i_step_ack),
		.i_retrain_req    (i_retrain_req),
		.i_error_req      (i_error_req),
		.i_degrade_req    (i_degrade_req),
		.o_mbtrain_ack    (o_mbtrain_ack),
		.o_phyretrain_en  (o_phyretrain_en),
		.step             (step_bus.seq)
	);

	// enables and sideband code
	substep_driver drv_i (
		.clk                 (clk),
		.rst_n               (rst_n),
		.step                (step_bus.user),
		.o_step_en           (o_step_en),
		.o_sideband_substate (o_sideband_substate),
		.o_mux_sel           (o_mux_sel)
	);

	lane_speed_tracker trk_i (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.step                   (step_bus.user),
		.i_highest_common_speed (i_highest_common_speed),
		.i_tx_lanes_mbinit      (i_tx_lanes_mbinit),
		.i_rx_lanes_mbinit      (i_rx_lanes_mbinit),
		.i_tx_lanes_linkspeed   (i_tx_lanes_linkspeed),
		.i_rx_lanes_repair      (i_rx_lanes_repair),
		.o_current_speed        (o_current_speed),
		.o_tx_lanes             (o_tx_lanes),
		.o_rx_lanes             (o_rx_lanes),
		.o_coming_from_repair   (o_coming_from_repair)
	);

endmodule

/* hw/substep_driver.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module substep_driver (
	input  logic                       clk,
	input  logic                       rst_n,
	train_step_if.user                 step,
	output logic [`MBT_STEP_COUNT-1:0] o_step_en,
	output logic [`MBT_SUBSTATE_W-1:0] o_sideband_substate,
	output logic [`MBT_MUX_W-1:0]      o_mux_sel
);

	logic [`MBT_STEP_COUNT-1:0] en_d;

	// one-hot enable for the step in its run phase
	always_comb begin
		en_d = '0;
		for (int i = 0; i < `MBT_STEP_COUNT; i++) begin
			en_d[i] = step.active && (int'(step.step) == i);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_step_en           <= '0;
			o_sideband_substate <= '0;
			o_mux_sel           <= '0;
		end else begin
			o_step_en <= en_d;
			// code and select move together with the rising enable
			if (step.active) begin
				o_sideband_substate <= step.step;
				o_mux_sel           <= mbtrain_pkg::step_mux_sel(step.step);
			end else if (step.finished) begin
				o_sideband_substate <= '0;
			end
		end
	end

endmodule

/* hw/train_step_if.sv */
`timescale 1ns/1ps

interface train_step_if;
	mbtrain_pkg::step_t step;
	logic active;
	// one-cycle pulse as the sequencer leaves step
	logic done;
	mbtrain_pkg::step_t next_step;
	mbtrain_pkg::cause_t cause;
	logic finished;

	modport seq (
		output step, active, done, next_step, cause, finished
	);

	modport user (
		input step, active, done, next_step, cause, finished
	);
endinterface

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module mbtrain_tb -f flist.f -o mbtrain_sim
./obj_dir/mbtrain_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
	echo "simulation did not complete"
	exit 1
fi
echo "simulation passed"

/* test/mbtrain_assert.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module mbtrain_assert (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       i_en,
	input logic [`MBT_STEP_COUNT-1:0] i_step_ack,
	input logic [`MBT_SUBSTATE_W-1:0] i_step,
	input logic                       i_mbtrain_ack
);

	int fail_count = 0;

	// a new step enters its run phase only after every acknowledge was seen low
	ack_clear_at_step_start: assert property (@(posedge clk) disable iff (!rst_n)
		((i_step != $past(i_step)) && (i_step != mbtrain_pkg::step_none))
		|-> ($past(i_step_ack) == '0))
		else begin
			$error("step started while an acknowledge was high");
			fail_count++;
		end

	ack_drops_without_en: assert property (@(posedge clk) disable iff (!rst_n)
		!i_en |=> !i_mbtrain_ack)
		else begin
			$error("o_mbtrain_ack high after i_en fell");
			fail_count++;
		end

	ack_held_until_en_low: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mbtrain_ack && i_en) |=> i_mbtrain_ack)
		else begin
			$error("o_mbtrain_ack dropped while i_en was high");
			fail_count++;
		end

endmodule

bind mbtrain_sequencer mbtrain_assert asrt_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.i_en          (i_en),
	.i_step_ack    (i_step_ack),
	.i_step        (cur_step),
	.i_mbtrain_ack (o_mbtrain_ack)
);

/* test/mbtrain_checker.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module mbtrain_checker (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_en,
	input  logic [1:0]                  i_resolved_state,
	input  logic                        i_from_l1,
	input  logic [`MBT_SPEED_W-1:0]     i_highest_speed,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_mbinit,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_linkspeed,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_repair,
	input  logic [1:0]                  i_outcome0,
	input  logic [1:0]                  i_outcome1,
	input  logic [`MBT_STEP_COUNT-1:0]  i_step_en,
	input  logic [`MBT_SUBSTATE_W-1:0]  i_substate,
	input  logic [`MBT_MUX_W-1:0]       i_mux_sel,
	input  logic                        i_mbtrain_ack,
	input  logic                        i_phyretrain_en,
	input  logic [`MBT_SPEED_W-1:0]     i_speed,
	input  logic [`MBT_LANE_HALVES-1:0] i_tx_lanes,
	input  logic [`MBT_LANE_HALVES-1:0] i_rx_lanes,
	input  logic                        i_from_repair,
	output int                          o_errors
);

	// link speed outcome codes as the testbench encodes them
	localparam logic [1:0] OC_FINISH  = 2'd0;
	localparam logic [1:0] OC_RETRAIN = 2'd1;
	localparam logic [1:0] OC_DEGRADE = 2'd2;

	int                          exp_q[$];
	int                          pos;
	logic [`MBT_STEP_COUNT-1:0]  en_prev;
	logic [`MBT_STEP_COUNT-1:0]  rises;
	logic                        ack_prev;
	logic                        en_in_prev;
	logic                        done_seen;
	logic [`MBT_SPEED_W-1:0]     spd_m;
	logic [`MBT_LANE_HALVES-1:0] tx_m;
	logic [`MBT_LANE_HALVES-1:0] rx_m;
	logic                        rep_m;
	logic                        retrain_m;

	function automatic logic [2:0] expected_mux(input int s);
		case (s)
			2, 3: return 3'd1;
			11: return 3'd2;
			12: return 3'd3;
			5, 7, 10: return 3'd4;
			4, 9: return 3'd5;
			default: return 3'd0;
		endcase
	endfunction

	task automatic compare(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			o_errors++;
		end
	endtask

	// walk the step order from the entry point, updating the speed and lane model
	task automatic build_expected();
		int s;
		int k;
		logic [1:0] oc;
		exp_q.delete();
		pos = 0;
		k = 0;
		rep_m = 1'b0;
		retrain_m = 1'b0;
		s = 2;
		if (!i_from_l1) begin
			case (i_resolved_state)
				2'd0: s = 0;
				2'd1: s = 3;
				2'd2: s = 12;
				default: spd_m = spd_m - 3'd1;
			endcase
		end
		if (s == 0) begin
			tx_m = i_tx_mbinit;
			rx_m = i_rx_mbinit;
			rep_m = !(&i_tx_mbinit);
		end
		while (s != 15) begin
			exp_q.push_back(s);
			case (s)
				1: begin
					spd_m = i_highest_speed;
					s = 2;
				end
				11: begin
					oc = (k == 0) ? i_outcome0 : ((k == 1) ? i_outcome1 : OC_FINISH);
					k++;
					if (|i_tx_linkspeed)
						tx_m = i_tx_linkspeed & i_tx_mbinit;
					if (oc == OC_DEGRADE) begin
						spd_m = spd_m - 3'd1;
						s = 2;
					end else if (oc == OC_FINISH || oc == OC_RETRAIN) begin
						retrain_m = (oc == OC_RETRAIN);
						s = 15;
					end else begin
						s = 12;
					end
				end
				12: begin
					rep_m = 1'b1;
					rx_m = i_rx_repair;
					s = 3;
				end
				default: s = s + 1;
			endcase
		end
	endtask

	task automatic check_enable();
		int b;
		int idx;
		idx = -1;
		for (b = 0; b < `MBT_STEP_COUNT; b++) begin
			if (rises[b])
				idx = b;
		end
		if (!$onehot(i_step_en)) begin
			$display("Error at %0t: more than one step enable is high", $time);
			o_errors++;
		end
		if (pos >= exp_q.size()) begin
			$display("Error at %0t: step %0d enabled after the sequence ended", $time, idx);
			o_errors++;
		end else begin
			compare("o_step_en index", idx, exp_q[pos]);
		end
		compare("o_sideband_substate", int'(i_substate), idx);
		compare("o_mux_sel", int'(i_mux_sel), int'(expected_mux(idx)));
		pos++;
	endtask

	task automatic check_results();
		done_seen = 1'b1;
		if (pos != exp_q.size()) begin
			$display("Error at %0t: training finished after %0d steps, expected %0d",
				$time, pos, exp_q.size());
			o_errors++;
		end
		compare("o_current_speed", int'(i_speed), int'(spd_m));
		compare("o_tx_lanes", int'(i_tx_lanes), int'(tx_m));
		compare("o_rx_lanes", int'(i_rx_lanes), int'(rx_m));
		compare("o_coming_from_repair", int'(i_from_repair), int'(rep_m));
	endtask

	// samples at the rising edge see the values held during the past cycle
	always @(posedge clk) begin
		if (!rst_n) begin
			o_errors = 0;
			en_prev = '0;
			ack_prev = 1'b0;
			en_in_prev = 1'b0;
			done_seen = 1'b0;
			pos = 0;
			spd_m = '0;
			tx_m = '0;
			rx_m = '0;
			rep_m = 1'b0;
			retrain_m = 1'b0;
		end else begin
			if (i_en && !en_in_prev)
				build_expected();
			rises = i_step_en & ~en_prev;
			if (rises != '0)
				check_enable();
			if (i_mbtrain_ack && !ack_prev)
				check_results();
			if (done_seen && i_en) begin
				compare("o_mbtrain_ack", int'(i_mbtrain_ack), 1);
				compare("o_phyretrain_en", int'(i_phyretrain_en), int'(retrain_m));
			end else if (!done_seen) begin
				compare("o_phyretrain_en", int'(i_phyretrain_en), 0);
			end
			// one clock after i_en was seen low everything is quiet
			if (!en_in_prev && (i_step_en != '0 || i_mbtrain_ack)) begin
				$display("Error at %0t: enables or o_mbtrain_ack high after i_en fell", $time);
				o_errors++;
			end
			if (!i_en)
				done_seen = 1'b0;
			en_prev = i_step_en;
			ack_prev = i_mbtrain_ack;
			en_in_prev = i_en;
		end
	end

endmodule

/* test/mbtrain_tb.sv */
`timescale 1ns/1ps
`include "mbtrain_defs.svh"

module mbtrain_tb;

	typedef struct packed {
		logic [1:0] rs;
		logic       l1;
		logic [2:0] speed;
		logic [1:0] tx_mb;
		logic [1:0] rx_mb;
		logic [1:0] tx_ls;
		logic [1:0] rx_rep;
		logic [1:0] oc0;
		logic [1:0] oc1;
	} scenario_t;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic                        i_en;
	logic [1:0]                  i_resolved_state;
	logic                        i_coming_from_l1;
	logic [`MBT_STEP_COUNT-1:0]  i_step_ack;
	logic                        i_retrain_req;
	logic                        i_error_req;
	logic                        i_degrade_req;
	logic [`MBT_SPEED_W-1:0]     i_highest_common_speed;
	logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_mbinit;
	logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_mbinit;
	logic [`MBT_LANE_HALVES-1:0] i_tx_lanes_linkspeed;
	logic [`MBT_LANE_HALVES-1:0] i_rx_lanes_repair;
	logic [`MBT_STEP_COUNT-1:0]  o_step_en;
	logic [`MBT_SUBSTATE_W-1:0]  o_sideband_substate;
	logic [`MBT_MUX_W-1:0]       o_mux_sel;
	logic                        o_mbtrain_ack;
	logic                        o_phyretrain_en;
	logic [`MBT_SPEED_W-1:0]     o_current_speed;
	logic [`MBT_LANE_HALVES-1:0] o_tx_lanes;
	logic [`MBT_LANE_HALVES-1:0] o_rx_lanes;
	logic                        o_coming_from_repair;
	logic [1:0]                  outcome0;
	logic [1:0]                  outcome1;
	logic                        loaded = 1'b0;
	int                          chk_errors;
	int                          tb_errors;
	int                          total_errors;
	scenario_t                   scen_q[$];

	always #50 clk = ~clk;

	mbtrain_top dut_i (
		.clk(clk), .rst_n(rst_n), .i_en(i_en), .i_resolved_state(i_resolved_state),
		.i_coming_from_l1(i_coming_from_l1), .i_step_ack(i_step_ack),
		.i_retrain_req(i_retrain_req), .i_error_req(i_error_req),
		.i_degrade_req(i_degrade_req), .i_highest_common_speed(i_highest_common_speed),
		.i_tx_lanes_mbinit(i_tx_lanes_mbinit), .i_rx_lanes_mbinit(i_rx_lanes_mbinit),
		.i_tx_lanes_linkspeed(i_tx_lanes_linkspeed), .i_rx_lanes_repair(i_rx_lanes_repair),
		.o_step_en(o_step_en), .o_sideband_substate(o_sideband_substate),
		.o_mux_sel(o_mux_sel), .o_mbtrain_ack(o_mbtrain_ack),
		.o_phyretrain_en(o_phyretrain_en), .o_current_speed(o_current_speed),
		.o_tx_lanes(o_tx_lanes), .o_rx_lanes(o_rx_lanes),
		.o_coming_from_repair(o_coming_from_repair)
	);

	mbtrain_checker chk_i (
		.clk(clk), .rst_n(rst_n), .i_en(i_en), .i_resolved_state(i_resolved_state),
		.i_from_l1(i_coming_from_l1), .i_highest_speed(i_highest_common_speed),
		.i_tx_mbinit(i_tx_lanes_mbinit), .i_rx_mbinit(i_rx_lanes_mbinit),
		.i_tx_linkspeed(i_tx_lanes_linkspeed), .i_rx_repair(i_rx_lanes_repair),
		.i_outcome0(outcome0), .i_outcome1(outcome1), .i_step_en(o_step_en),
		.i_substate(o_sideband_substate), .i_mux_sel(o_mux_sel),
		.i_mbtrain_ack(o_mbtrain_ack), .i_phyretrain_en(o_phyretrain_en),
		.i_speed(o_current_speed), .i_tx_lanes(o_tx_lanes), .i_rx_lanes(o_rx_lanes),
		.i_from_repair(o_coming_from_repair), .o_errors(chk_errors)
	);

	// F finish 0, R retrain 1, D degrade 2, P repair 3
	function automatic logic [1:0] outcome_code(input logic [7:0] c);
		case (c)
			"R": return 2'd1;
			"D": return 2'd2;
			"P": return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	function automatic logic [3:0] lowest_enable(input logic [`MBT_STEP_COUNT-1:0] v);
		int b;
		lowest_enable = 4'd0;
		for (b = `MBT_STEP_COUNT - 1; b >= 0; b--) begin
			if (v[b])
				lowest_enable = 4'(b);
		end
	endfunction

	task automatic load_tests();
		int fd;
		int n;
		int rs;
		int l1;
		int sp;
		int txm;
		int rxm;
		int txl;
		int rxr;
		logic [7:0] c0;
		logic [7:0] c1;
		logic [8*128-1:0] line;
		scenario_t sc;
		fd = $fopen("test/mbtrain_tests.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open test/mbtrain_tests.txt");
			tb_errors++;
			return;
		end
		// comment lines fail the numeric scan and are skipped
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%d %d %d %b %b %b %b %s %s",
				rs, l1, sp, txm, rxm, txl, rxr, c0, c1);
			if (n == 9) begin
				sc.rs = rs[1:0];
				sc.l1 = l1[0];
				sc.speed = sp[2:0];
				sc.tx_mb = txm[1:0];
				sc.rx_mb = rxm[1:0];
				sc.tx_ls = txl[1:0];
				sc.rx_rep = rxr[1:0];
				sc.oc0 = outcome_code(c0);
				sc.oc1 = outcome_code(c1);
				scen_q.push_back(sc);
			end
		end
		$fclose(fd);
	endtask

	task automatic present_flags(input logic [1:0] oc);
		i_retrain_req = (oc == 2'd1);
		i_error_req = (oc == 2'd2) || (oc == 2'd3);
		i_degrade_req = (oc == 2'd2);
	endtask

	// acknowledge each enable with random latency until training finishes
	task automatic run_scenario(input scenario_t sc);
		logic [3:0] idx;
		int oc_idx;
		i_resolved_state = sc.rs;
		i_coming_from_l1 = sc.l1;
		i_highest_common_speed = sc.speed;
		i_tx_lanes_mbinit = sc.tx_mb;
		i_rx_lanes_mbinit = sc.rx_mb;
		i_tx_lanes_linkspeed = sc.tx_ls;
		i_rx_lanes_repair = sc.rx_rep;
		outcome0 = sc.oc0;
		outcome1 = sc.oc1;
		i_en = 1'b1;
		oc_idx = 0;
		while (!o_mbtrain_ack) begin
			@(negedge clk);
			if (o_step_en != '0) begin
				idx = lowest_enable(o_step_en);
				if (idx == 4'd11) begin
					present_flags((oc_idx == 0) ? sc.oc0 : ((oc_idx == 1) ? sc.oc1 : 2'd0));
					oc_idx++;
				end
				repeat ($urandom_range(3, 0)) @(negedge clk);
				i_step_ack[idx] = 1'b1;
				while (o_step_en[idx])
					@(negedge clk);
				repeat ($urandom_range(3, 0)) @(negedge clk);
				i_step_ack[idx] = 1'b0;
				present_flags(2'd0);
			end
		end
		repeat (3) @(negedge clk);
		i_en = 1'b0;
		repeat (5) @(negedge clk);
	endtask

	initial begin
		rst_n = 1'b0;
		i_en = 1'b0;
		i_resolved_state = 2'd0;
		i_coming_from_l1 = 1'b0;
		i_step_ack = '0;
		present_flags(2'd0);
		i_highest_common_speed = '0;
		i_tx_lanes_mbinit = '0;
		i_rx_lanes_mbinit = '0;
		i_tx_lanes_linkspeed = '0;
		i_rx_lanes_repair = '0;
		outcome0 = 2'd0;
		outcome1 = 2'd0;
		tb_errors = 0;
		void'($urandom(41396));
		load_tests();
		loaded = 1'b1;
		if (scen_q.size() == 0) begin
			$display("Error: no scenarios were read from the test file");
			tb_errors++;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		foreach (scen_q[i])
			run_scenario(scen_q[i]);
		repeat (4) @(negedge clk);
		total_errors = chk_errors + tb_errors + dut_i.seq_i.asrt_i.fail_count;
		$display("errors: checker %0d, assertions %0d, testbench %0d",
			chk_errors, dut_i.seq_i.asrt_i.fail_count, tb_errors);
		if (total_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog, 400 cycles per scenario plus reset
	initial begin
		wait (loaded);
		repeat ((scen_q.size() + 1) * 400) @(posedge clk);
		$display("Error: timeout, training did not finish within %0d cycles",
			(scen_q.size() + 1) * 400);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* test/mbtrain_tests.txt */
# resolved_state l1 highest_speed tx_mbinit rx_mbinit tx_linkspeed rx_repair outcome1 outcome2
# outcomes: F finish, R retrain, D degrade, P repair; later link speed passes finish
0 0 5 11 11 00 11 F F
0 0 6 01 11 00 10 P F
0 0 4 11 11 11 11 D F
1 0 4 11 11 10 11 F F
2 0 7 11 11 00 01 F F
3 0 6 11 11 00 11 R F
0 1 3 11 11 00 11 D R
0 0 3 10 11 01 11 P D
3 1 5 11 01 00 11 F F
1 0 2 11 11 11 10 P P
0 0 7 11 10 00 11 R F
